// ==== usb_prot_decoder.f ====
verilog/usb_prot_pkg.sv
verilog/crc8_pkg.sv
verilog/frame_parser.sv
verilog/payload_packer.sv
verilog/usb_prot_decoder.sv
dv/tb_usb_prot_decoder.sv

// ==== run.sh ====
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --assert -Wno-fatal \
	--top-module tb_usb_prot_decoder \
	-f usb_prot_decoder.f \
	-o sim_usb_prot_decoder &&
./obj_dir/sim_usb_prot_decoder ||
{ echo "Simulation failed"; exit 1; }

// ==== dv/usb_prot_stimulus.txt ====
# Drive: D op_i rcv_off_i op_be_i op_dat_i    Idle: I cycles
# Expect: W dat_o dat_be_o | C crc_ok addr len | H (header CRC error)
# case 1: aligned sync, 9-byte payload in full words
D 1 0 4 5E4D2100
D 1 0 4 09DA0102
D 1 0 4 03040506
D 1 0 4 07080985
W 01020304 4
W 05060708 4
W 09000000 1
C 1 21 0009
I 3
# case 2: noise, repeated 5E, sync split across words, varied counts
D 1 0 2 115EFFFF
D 1 0 1 5EFFFFFF
D 1 0 3 4D2100FF
I 1
D 1 0 1 09FFFFFF
D 1 0 4 DA010203
D 1 0 2 0405FFFF
I 2
D 1 0 3 060708FF
D 1 0 2 0985FFFF
W 01020304 4
W 05060708 4
W 09000000 1
C 1 21 0009
I 3
# case 3: bad header CRC, then a valid 3-byte frame
D 1 0 4 5E4D2100
D 1 0 4 09DB0102
D 1 0 4 03040506
D 1 0 4 07080985
H
D 1 0 4 5E4D4200
D 1 0 4 0394A0B1
D 1 0 2 C252FFFF
W A0B1C200 3
C 1 42 0003
I 3
# case 4: bad payload CRC byte
D 1 0 4 5E4D2100
D 1 0 4 09DA0102
D 1 0 4 03040506
D 1 0 4 07080984
W 01020304 4
W 05060708 4
W 09000000 1
C 0 21 0009
I 3
# case 5: receive off in mid payload, rest of frame ignored
D 1 0 4 5E4D2100
D 1 0 4 09DA0102
I 1
D 0 1 0 00000000
D 0 1 0 00000000
D 1 0 4 03040506
D 1 0 4 07080985
I 1
D 1 0 4 5E4D4200
D 1 0 4 0394A0B1
D 1 0 2 C252FFFF
W A0B1C200 3
C 1 42 0003
I 3
# case 6: zero-length frame, then a frame in the next word
D 1 0 4 5E4D0700
D 1 0 4 00DB005E
D 1 0 4 4D5E4D42
D 1 0 4 000394A0
D 1 0 3 B1C252FF
C 1 07 0000
W A0B1C200 3
C 1 42 0003
I 4

// ==== dv/tb_usb_prot_decoder.sv ====
module tb_usb_prot_decoder;

	localparam int CLK_PERIOD = 100;
	localparam int DRIVE_DELAY = 10;
	localparam int TIMEOUT_MARGIN = 20;
	localparam string STIM_FILE = "dv/usb_prot_stimulus.txt";

	typedef enum logic [1:0]
	{
		EV_WORD,
		EV_DONE,
		EV_HDR
	} ev_kind_t;

	// One input cycle
	typedef struct packed
	{
		logic op;
		logic rcv_off;
		usb_prot_pkg::cnt_t be;
		usb_prot_pkg::word_t dat;
	} drive_t;

	// One expected output event
	typedef struct packed
	{
		ev_kind_t kind;
		usb_prot_pkg::word_t dat;
		usb_prot_pkg::cnt_t be;
		logic ok;
		usb_prot_pkg::byte_t addr;
		usb_prot_pkg::len_t len;
	} event_t;

	logic clk;
	logic rst_n;
	logic op_i;
	usb_prot_pkg::word_t op_dat_i;
	usb_prot_pkg::cnt_t op_be_i;
	logic rcv_off_i;
	logic dat_en_o;
	usb_prot_pkg::word_t dat_o;
	usb_prot_pkg::cnt_t dat_be_o;
	usb_prot_pkg::byte_t dat_addr_o;
	usb_prot_pkg::len_t dat_len_o;
	logic trsmt_cmplt_o;
	logic dat_crc_chk_o;
	logic dat_crc_err_o;
	logic hdr_err_o;

	drive_t drive_q[$];
	event_t exp_q[$];
	int cycle_cnt;
	int cycle_limit;

	usb_prot_decoder dut0 (
		.clk(clk),
		.rst_n(rst_n),
		.op_i(op_i),
		.op_dat_i(op_dat_i),
		.op_be_i(op_be_i),
		.rcv_off_i(rcv_off_i),
		.dat_en_o(dat_en_o),
		.dat_o(dat_o),
		.dat_be_o(dat_be_o),
		.dat_addr_o(dat_addr_o),
		.dat_len_o(dat_len_o),
		.trsmt_cmplt_o(trsmt_cmplt_o),
		.dat_crc_chk_o(dat_crc_chk_o),
		.dat_crc_err_o(dat_crc_err_o),
		.hdr_err_o(hdr_err_o)
	);

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("*** TEST FAILED ***");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
		if (got !== exp)
			abort_run($sformatf("** Error at time %0t: %s is %h, expected %h",
				$time, what, got, exp));
	endtask

	// Drive lines expand into the cycle list, expect lines into the event queue
	task automatic load_stimulus();
		int fd;
		int n;
		logic [7:0] tag;
		logic [31:0] f0;
		logic [31:0] f1;
		logic [31:0] f2;
		logic [31:0] f3;
		logic [8*160-1:0] rest;
		drive_t d;
		event_t e;
		fd = $fopen(STIM_FILE, "r");
		if (fd == 0)
			abort_run($sformatf("Cannot open stimulus file %s", STIM_FILE));
		else
		begin
			while ($fscanf(fd, "%s", tag) == 1)
			begin
				d = '0;
				e = '0;
				n = 0;
				case (tag)
					"#": n = $fgets(rest, fd);
					"D":
					begin
						n = $fscanf(fd, "%h %h %h %h", f0, f1, f2, f3);
						d.op = f0[0];
						d.rcv_off = f1[0];
						d.be = f2[2:0];
						d.dat = f3;
						drive_q.push_back(d);
					end
					"I":
					begin
						n = $fscanf(fd, "%d", f0);
						repeat (f0)
							drive_q.push_back(d);
					end
					"W":
					begin
						n = $fscanf(fd, "%h %h", f0, f1);
						e.kind = EV_WORD;
						e.dat = f0;
						e.be = f1[2:0];
						exp_q.push_back(e);
					end
					"C":
					begin
						n = $fscanf(fd, "%h %h %h", f0, f1, f2);
						e.kind = EV_DONE;
						e.ok = f0[0];
						e.addr = f1[7:0];
						e.len = f2[15:0];
						exp_q.push_back(e);
					end
					"H":
					begin
						e.kind = EV_HDR;
						exp_q.push_back(e);
					end
					default: abort_run($sformatf("Unknown line type %s in stimulus file", tag));
				endcase
				if (n < 0)
					abort_run("Stimulus file ends in the middle of a line");
			end
			$fclose(fd);
		end
	endtask

	task automatic pop_expected(input string what, output event_t e);
		if (exp_q.size() == 0)
			abort_run($sformatf("Unexpected %s at time %0t with no event left to match",
				what, $time));
		else
			e = exp_q.pop_front();
	endtask

	// Events within one cycle are matched word first, then completion, then header error
	task automatic check_outputs();
		event_t e;
		if (dat_en_o)
		begin
			pop_expected("output word", e);
			check_value(32'(e.kind), 32'(EV_WORD), "event kind at output word");
			check_value(dat_o, e.dat, "dat_o");
			check_value(32'(dat_be_o), 32'(e.be), "dat_be_o");
		end
		if (trsmt_cmplt_o)
		begin
			pop_expected("completion", e);
			check_value(32'(e.kind), 32'(EV_DONE), "event kind at completion");
			check_value(32'(dat_crc_chk_o), 32'(e.ok), "dat_crc_chk_o");
			check_value(32'(dat_crc_err_o), 32'(!e.ok), "dat_crc_err_o");
			check_value(32'(dat_addr_o), 32'(e.addr), "dat_addr_o");
			check_value(32'(dat_len_o), 32'(e.len), "dat_len_o");
		end
		else
			check_value(32'(dat_crc_err_o), 32'd0, "dat_crc_err_o without completion");
		if (hdr_err_o)
		begin
			pop_expected("header error", e);
			check_value(32'(e.kind), 32'(EV_HDR), "event kind at header error");
		end
	endtask

	initial
	begin
		clk = 1'b0;
		forever
		begin
			#(CLK_PERIOD / 2);
			clk = ~clk;
		end
	end

	// Outputs settle well before the falling edge
	always @(negedge clk)
	begin
		if (rst_n)
			check_outputs();
	end

	always @(posedge clk)
	begin
		if (rst_n)
		begin
			cycle_cnt = cycle_cnt + 1;
			if (cycle_cnt > cycle_limit)
				abort_run($sformatf("Timeout after %0d cycles with %0d events still expected",
					cycle_limit, exp_q.size()));
		end
	end

	initial
	begin
		drive_t d;
		op_i = 1'b0;
		op_dat_i = '0;
		op_be_i = '0;
		rcv_off_i = 1'b0;
		rst_n = 1'b0;
		cycle_cnt = 0;
		load_stimulus();
		cycle_limit = drive_q.size() + TIMEOUT_MARGIN;

		repeat (2) @(posedge clk);
		#(DRIVE_DELAY);
		rst_n = 1'b1;

		while (drive_q.size() != 0)
		begin
			d = drive_q.pop_front();
			@(posedge clk);
			#(DRIVE_DELAY);
			op_i = d.op;
			rcv_off_i = d.rcv_off;
			op_be_i = d.be;
			op_dat_i = d.dat;
		end
		@(posedge clk);
		#(DRIVE_DELAY);
		op_i = 1'b0;
		rcv_off_i = 1'b0;

		// Wait for the last frame to drain
		while (exp_q.size() != 0)
			@(posedge clk);
		repeat (4) @(posedge clk);

		$display("*** TEST PASSED ***");
		$finish;
	end

endmodule

// ==== verilog/usb_prot_decoder.sv ====
module usb_prot_decoder (
	input logic clk,
	input logic rst_n,
	input logic op_i,
	input usb_prot_pkg::word_t op_dat_i,
	input usb_prot_pkg::cnt_t op_be_i,
	input logic rcv_off_i,
	output logic dat_en_o,
	output usb_prot_pkg::word_t dat_o,
	output usb_prot_pkg::cnt_t dat_be_o,
	output usb_prot_pkg::byte_t dat_addr_o,
	output usb_prot_pkg::len_t dat_len_o,
	output logic trsmt_cmplt_o,
	output logic dat_crc_chk_o,
	output logic dat_crc_err_o,
	output logic hdr_err_o
);

	usb_prot_pkg::lane_word_t lanes;
	logic lanes_vld;
	usb_prot_pkg::hdr_t hdr;

	frame_parser u_parser (
		.clk(clk),
		.rst_n(rst_n),
		.op_i(op_i),
		.op_dat_i(op_dat_i),
		.op_be_i(op_be_i),
		.rcv_off_i(rcv_off_i),
		.lanes_o(lanes),
		.lanes_vld_o(lanes_vld),
		.hdr_o(hdr),
		.hdr_err_o(hdr_err_o)
	);

	payload_packer u_packer (
		.clk(clk),
		.rst_n(rst_n),
		.rcv_off_i(rcv_off_i),
		.lanes_i(lanes),
		.lanes_vld_i(lanes_vld),
		.dat_en_o(dat_en_o),
		.dat_o(dat_o),
		.dat_be_o(dat_be_o),
		.trsmt_cmplt_o(trsmt_cmplt_o),
		.dat_crc_chk_o(dat_crc_chk_o),
		.dat_crc_err_o(dat_crc_err_o)
	);

	// Header fields stay put for the whole frame
	assign dat_addr_o = hdr.addr;
	assign dat_len_o = hdr.len;

endmodule

// ==== verilog/payload_packer.sv ====
module payload_packer (
	input logic clk,
	input logic rst_n,
	input logic rcv_off_i,
	input usb_prot_pkg::lane_word_t lanes_i,
	input logic lanes_vld_i,
	output logic dat_en_o,
	output usb_prot_pkg::word_t dat_o,
	output usb_prot_pkg::cnt_t dat_be_o,
	output logic trsmt_cmplt_o,
	output logic dat_crc_chk_o,
	output logic dat_crc_err_o
);

	localparam int BUF_BYTES = 2 * usb_prot_pkg::LANES - 1;

	usb_prot_pkg::byte_t [BUF_BYTES-1:0] buf_q;
	usb_prot_pkg::byte_t [BUF_BYTES-1:0] n_buf;
	usb_prot_pkg::byte_t [BUF_BYTES-1:0] post_buf;
	logic [3:0] fill_q;
	logic [3:0] n_fill;
	logic [3:0] post_fill;
	usb_prot_pkg::byte_t crc_q;
	usb_prot_pkg::byte_t n_crc;
	logic pend_q;
	logic n_pend;
	logic ok_q;
	logic n_ok;
	logic got_crc;
	logic crc_ok;

	usb_prot_pkg::byte_t [usb_prot_pkg::LANES-1:0] e_src;
	usb_prot_pkg::word_t e_word;
	usb_prot_pkg::cnt_t e_be;
	logic e_en;
	logic e_cmplt;
	logic e_chk;

	always_comb
	begin
		n_buf = buf_q;
		// A pending flush empties the buffer this cycle
		n_fill = pend_q ? 4'd0 : fill_q;
		n_crc = crc_q;
		got_crc = 1'b0;
		crc_ok = 1'b0;
		if (lanes_vld_i)
		begin
			for (int j = 0; j < usb_prot_pkg::LANES; j++)
			begin
				if (lanes_i.kind[usb_prot_pkg::LANES-1-j] == usb_prot_pkg::PAYLOAD)
				begin
					n_buf[BUF_BYTES - 1 - int'(n_fill)] = lanes_i.data[usb_prot_pkg::LANES-1-j];
					n_fill = n_fill + 4'd1;
					n_crc = crc8_pkg::crc8_step(n_crc, lanes_i.data[usb_prot_pkg::LANES-1-j]);
				end
				else if (lanes_i.kind[usb_prot_pkg::LANES-1-j] == usb_prot_pkg::CRC)
				begin
					got_crc = 1'b1;
					crc_ok = (lanes_i.data[usb_prot_pkg::LANES-1-j] == n_crc);
				end
			end
		end

		post_buf = n_buf;
		post_fill = n_fill;
		n_pend = 1'b0;
		n_ok = ok_q;
		e_src = n_buf[BUF_BYTES-1 -: usb_prot_pkg::LANES];
		e_be = '0;
		e_en = 1'b0;
		e_cmplt = 1'b0;
		e_chk = 1'b0;

		if (pend_q)
		begin
			e_src = buf_q[BUF_BYTES-1 -: usb_prot_pkg::LANES];
			e_be = fill_q[2:0];
			e_en = (fill_q != 4'd0);
			e_cmplt = 1'b1;
			e_chk = ok_q;
		end
		else if (n_fill >= 4'd4)
		begin
			e_be = 3'd4;
			e_en = 1'b1;
			post_buf = {n_buf[2:0], n_buf[BUF_BYTES-1 -: usb_prot_pkg::LANES]};
			post_fill = n_fill - 4'd4;
			if (got_crc)
			begin
				if (post_fill == 4'd0)
				begin
					e_cmplt = 1'b1;
					e_chk = crc_ok;
				end
				else
				begin
					n_pend = 1'b1;
					n_ok = crc_ok;
				end
			end
		end
		else if (got_crc)
		begin
			e_be = n_fill[2:0];
			e_en = (n_fill != 4'd0);
			e_cmplt = 1'b1;
			e_chk = crc_ok;
			post_fill = 4'd0;
		end

		// Zero the unused low lanes
		for (int k = 0; k < usb_prot_pkg::LANES; k++)
		begin
			if (k < e_be)
				e_word[8*(usb_prot_pkg::LANES-1-k) +: 8] = e_src[usb_prot_pkg::LANES-1-k];
			else
				e_word[8*(usb_prot_pkg::LANES-1-k) +: 8] = 8'h00;
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			fill_q <= 4'd0;
			crc_q <= crc8_pkg::DATA_SEED;
			pend_q <= 1'b0;
			ok_q <= 1'b0;
			dat_en_o <= 1'b0;
			trsmt_cmplt_o <= 1'b0;
			dat_crc_chk_o <= 1'b0;
			dat_crc_err_o <= 1'b0;
		end
		else if (rcv_off_i)
		begin
			fill_q <= 4'd0;
			crc_q <= crc8_pkg::DATA_SEED;
			pend_q <= 1'b0;
			ok_q <= 1'b0;
			dat_en_o <= 1'b0;
			trsmt_cmplt_o <= 1'b0;
			dat_crc_chk_o <= 1'b0;
			dat_crc_err_o <= 1'b0;
		end
		else
		begin
			fill_q <= post_fill;
			crc_q <= got_crc ? crc8_pkg::DATA_SEED : n_crc;
			pend_q <= n_pend;
			ok_q <= n_ok;
			dat_en_o <= e_en;
			trsmt_cmplt_o <= e_cmplt;
			dat_crc_chk_o <= e_chk;
			dat_crc_err_o <= e_cmplt && !e_chk;
		end
	end

	always_ff @(posedge clk)
	begin
		buf_q <= post_buf;
		dat_o <= e_word;
		dat_be_o <= e_be;
	end

	// Parser brings at most one word of lanes per drained buffer
	a_fill_max: assert property (@(posedge clk) disable iff (!rst_n)
		lanes_vld_i |-> (n_fill <= 4'(BUF_BYTES)))
		else $error("holding buffer overflow");

	a_be_nonzero: assert property (@(posedge clk) disable iff (!rst_n)
		dat_en_o |-> (dat_be_o != '0))
		else $error("output word with zero byte count");

endmodule

// ==== verilog/frame_parser.sv ====
module frame_parser (
	input logic clk,
	input logic rst_n,
	input logic op_i,
	input usb_prot_pkg::word_t op_dat_i,
	input usb_prot_pkg::cnt_t op_be_i,
	input logic rcv_off_i,
	output usb_prot_pkg::lane_word_t lanes_o,
	output logic lanes_vld_o,
	output usb_prot_pkg::hdr_t hdr_o,
	output logic hdr_err_o
);

	typedef enum logic [2:0]
	{
		HUNT,
		GOT_5E,
		HEADER,
		PAYLOAD,
		CRC
	} state_t;

	state_t st_q;
	state_t n_st;

	logic op_q;
	usb_prot_pkg::word_t dat_q;
	usb_prot_pkg::cnt_t be_q;

	logic [1:0] hcnt_q;
	logic [1:0] n_hcnt;
	usb_prot_pkg::byte_t hcrc_q;
	usb_prot_pkg::byte_t n_hcrc;
	usb_prot_pkg::len_t rem_q;
	usb_prot_pkg::len_t n_rem;
	usb_prot_pkg::hdr_t hwork_q;
	usb_prot_pkg::hdr_t n_hwork;
	usb_prot_pkg::hdr_t hdr_q;
	usb_prot_pkg::hdr_t n_hdr;

	usb_prot_pkg::lane_word_t lanes;
	usb_prot_pkg::byte_t cur_b;
	logic run;
	logic done;
	logic hdr_bad;

	// Input word register
	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
			op_q <= 1'b0;
		else if (rcv_off_i)
			op_q <= 1'b0;
		else
			op_q <= op_i;
	end

	always_ff @(posedge clk)
	begin
		if (op_i)
		begin
			dat_q <= op_dat_i;
			be_q <= op_be_i;
		end
	end

	assign run = op_q && !rcv_off_i;

	// Walk the lanes top down, one FSM step per valid byte
	always_comb
	begin
		n_st = st_q;
		n_hcnt = hcnt_q;
		n_hcrc = hcrc_q;
		n_rem = rem_q;
		n_hwork = hwork_q;
		n_hdr = hdr_q;
		hdr_bad = 1'b0;
		done = 1'b0;
		cur_b = '0;
		lanes.data = dat_q;
		for (int k = 0; k < usb_prot_pkg::LANES; k++)
			lanes.kind[k] = usb_prot_pkg::NONE;

		for (int j = 0; j < usb_prot_pkg::LANES; j++)
		begin
			if (run && !done && (j < be_q))
			begin
				cur_b = dat_q[8*(usb_prot_pkg::LANES-1-j) +: 8];
				case (n_st)
					HUNT:
					begin
						if (cur_b == usb_prot_pkg::SYNC_HI)
							n_st = GOT_5E;
					end
					GOT_5E:
					begin
						if (cur_b == usb_prot_pkg::SYNC_LO)
						begin
							n_st = HEADER;
							n_hcnt = 2'd0;
							n_hcrc = crc8_pkg::HDR_SEED;
						end
						else if (cur_b != usb_prot_pkg::SYNC_HI)
							n_st = HUNT;
					end
					HEADER:
					begin
						case (n_hcnt)
							2'd0: n_hwork.addr = cur_b;
							2'd1: n_hwork.len[15:8] = cur_b;
							2'd2: n_hwork.len[7:0] = cur_b;
							default: ;
						endcase
						if (n_hcnt == 2'(usb_prot_pkg::HDR_BYTES - 1))
						begin
							if (cur_b == n_hcrc)
							begin
								n_hdr = n_hwork;
								n_rem = n_hwork.len;
								if (n_hwork.len == '0)
									n_st = CRC;
								else
									n_st = PAYLOAD;
							end
							else
							begin
								// Bad header, drop rest of word
								hdr_bad = 1'b1;
								done = 1'b1;
								n_st = HUNT;
							end
						end
						else
						begin
							n_hcrc = crc8_pkg::crc8_step(n_hcrc, cur_b);
							n_hcnt = n_hcnt + 2'd1;
						end
					end
					PAYLOAD:
					begin
						lanes.kind[usb_prot_pkg::LANES-1-j] = usb_prot_pkg::PAYLOAD;
						n_rem = n_rem - 16'd1;
						if (n_rem == '0)
							n_st = CRC;
					end
					CRC:
					begin
						lanes.kind[usb_prot_pkg::LANES-1-j] = usb_prot_pkg::CRC;
						done = 1'b1;
						n_st = HUNT;
					end
					default: n_st = HUNT;
				endcase
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			st_q <= HUNT;
			hcnt_q <= 2'd0;
			hcrc_q <= crc8_pkg::HDR_SEED;
			rem_q <= '0;
			hdr_q <= '0;
		end
		else if (rcv_off_i)
		begin
			st_q <= HUNT;
			hcnt_q <= 2'd0;
			hcrc_q <= crc8_pkg::HDR_SEED;
			rem_q <= '0;
			hdr_q <= '0;
		end
		else
		begin
			st_q <= n_st;
			hcnt_q <= n_hcnt;
			hcrc_q <= n_hcrc;
			rem_q <= n_rem;
			hdr_q <= n_hdr;
		end
	end

	// Partial header bytes
	always_ff @(posedge clk)
	begin
		hwork_q <= n_hwork;
	end

	assign lanes_o = lanes;
	assign lanes_vld_o = run;
	assign hdr_o = hdr_q;
	assign hdr_err_o = hdr_bad;

	a_be_range: assert property (@(posedge clk) disable iff (!rst_n)
		op_i |-> (op_be_i != 3'd0) && (op_be_i <= 3'd4))
		else $error("op_be_i out of range with op_i high");

	// Counter hits zero on the last payload lane, never below
	a_rem_nowrap: assert property (@(posedge clk) disable iff (!rst_n)
		(st_q == PAYLOAD) |-> (rem_q != '0))
		else $error("payload counter wrapped");

endmodule

// ==== verilog/crc8_pkg.sv ====
package crc8_pkg;

	localparam logic [7:0] CRC_POLY = 8'h07;

	// CRC of the sync pair 5E 4D
	localparam logic [7:0] HDR_SEED = 8'h3E;
	localparam logic [7:0] DATA_SEED = 8'h00;

	// MSB first, one byte per call
	function automatic logic [7:0] crc8_step(input logic [7:0] crc, input logic [7:0] data);
		logic [7:0] c;
		c = crc ^ data;
		for (int i = 0; i < 8; i++)
		begin
			if (c[7])
				c = (c << 1) ^ CRC_POLY;
			else
				c = c << 1;
		end
		return c;
	endfunction

endpackage

// ==== verilog/usb_prot_pkg.sv ====
package usb_prot_pkg;

	// Frame layout
	localparam int LANES = 4;
	localparam int HDR_BYTES = 4;

	typedef logic [7:0] byte_t;
	typedef logic [31:0] word_t;
	typedef logic [2:0] cnt_t;
	typedef logic [15:0] len_t;

	localparam byte_t SYNC_HI = 8'h5E;
	localparam byte_t SYNC_LO = 8'h4D;

	// Role of one byte lane after the parser
	typedef enum logic [1:0]
	{
		NONE,
		PAYLOAD,
		CRC
	} lane_kind_t;

	// Lane 3 is the top byte, bits 31:24 of the bus word
	typedef struct packed
	{
		byte_t [LANES-1:0] data;
		lane_kind_t [LANES-1:0] kind;
	} lane_word_t;

	typedef struct packed
	{
		byte_t addr;
		len_t len;
	} hdr_t;

endpackage
